// ==== common/cpu_pkg.sv ====
package cpu_pkg;

  localparam int DATA_WIDTH = 8;
  localparam int ADDR_WIDTH = 16;

  typedef logic [DATA_WIDTH-1:0] byte_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // Instruction stages, reset fetch runs before the first opcode
  typedef enum logic [2:0] {
    STAGE_FETCH    = 3'd0,
    STAGE_1        = 3'd1,
    STAGE_2        = 3'd2,
    STAGE_3        = 3'd3,
    STAGE_RESET_LO = 3'd4,
    STAGE_RESET_HI = 3'd5
  } stage_t;

  // Loads
  localparam byte_t OP_LDA_IMM = 8'hA9;
  localparam byte_t OP_LDA_ZP  = 8'hA5;
  localparam byte_t OP_LDA_ZPX = 8'hB5;
  localparam byte_t OP_LDA_ABS = 8'hAD;
  localparam byte_t OP_LDX_IMM = 8'hA2;
  localparam byte_t OP_LDX_ZP  = 8'hA6;
  localparam byte_t OP_LDY_IMM = 8'hA0;
  localparam byte_t OP_LDY_ZP  = 8'hA4;

  // Store, arithmetic, flow
  localparam byte_t OP_STA_ZP  = 8'h85;
  localparam byte_t OP_ADC_IMM = 8'h69;
  localparam byte_t OP_JMP_ABS = 8'h4C;
  localparam byte_t OP_NOP     = 8'hEA;

  // Register transfers
  localparam byte_t OP_TAX = 8'hAA;
  localparam byte_t OP_TAY = 8'hA8;
  localparam byte_t OP_TXA = 8'h8A;
  localparam byte_t OP_TYA = 8'h98;
  localparam byte_t OP_TXS = 8'h9A;
  localparam byte_t OP_TSX = 8'hBA;

  // Reset vector
  localparam addr_t VECTOR_LO_ADDR = 16'hFFFC;
  localparam addr_t VECTOR_HI_ADDR = 16'hFFFD;

endpackage

// ==== verilog/clock_enable.sv ====
`timescale 1ns/1ps

module clock_enable #(
  parameter int unsigned CLOCK_DIVIDER = 4
) (
  input  logic clock_i,
  input  logic reset_i,
  output logic step_o
);

  localparam int COUNT_WIDTH = (CLOCK_DIVIDER > 1) ? $clog2(CLOCK_DIVIDER) : 1;

  logic [COUNT_WIDTH-1:0] count;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      count  <= '0;
      step_o <= 1'b0;
    end else if (count == COUNT_WIDTH'(CLOCK_DIVIDER - 1)) begin
      count  <= '0;
      step_o <= 1'b1;
    end else begin
      count  <= count + 1'b1;
      step_o <= 1'b0;
    end
  end

endmodule

// ==== cpu_core/cpu_control.sv ====
`timescale 1ns/1ps

module cpu_control
  import cpu_pkg::*;
(
  input  logic  clock_i,
  input  logic  reset_i,
  input  logic  step_i,
  input  byte_t data_i,
  input  logic  data_valid_i,
  output logic  bus_read_o,
  output logic  bus_write_o,
  output logic  data_to_acc_o,
  output logic  data_to_x_o,
  output logic  data_to_y_o,
  output logic  data_to_addr_low_o,
  output logic  data_to_addr_high_o,
  output logic  zero_to_addr_high_o,
  output logic  data_to_pc_low_o,
  output logic  data_to_pc_high_o,
  output logic  data_to_hold_o,
  output logic  hold_to_addr_low_o,
  output logic  hold_to_acc_o,
  output logic  acc_to_alu_o,
  output logic  x_to_alu_o,
  output logic  alu_to_hold_o,
  output logic  acc_to_data_o,
  output logic  acc_to_x_o,
  output logic  acc_to_y_o,
  output logic  x_to_acc_o,
  output logic  y_to_acc_o,
  output logic  x_to_sp_o,
  output logic  sp_to_x_o,
  output logic  pc_low_to_addr_low_o,
  output logic  inc_pc_to_pc_o,
  output logic  inc_pc_to_addr_o,
  output logic  vector_hi_to_addr_o
);

  stage_t stage;
  stage_t next_stage;
  byte_t  opcode;
  logic   load_opcode;
  logic   finish;
  logic   bus_read;
  logic   bus_write;

  always_comb begin
    data_to_acc_o        = 1'b0;
    data_to_x_o          = 1'b0;
    data_to_y_o          = 1'b0;
    data_to_addr_low_o   = 1'b0;
    data_to_addr_high_o  = 1'b0;
    zero_to_addr_high_o  = 1'b0;
    data_to_pc_low_o     = 1'b0;
    data_to_pc_high_o    = 1'b0;
    data_to_hold_o       = 1'b0;
    hold_to_addr_low_o   = 1'b0;
    hold_to_acc_o        = 1'b0;
    acc_to_alu_o         = 1'b0;
    x_to_alu_o           = 1'b0;
    alu_to_hold_o        = 1'b0;
    acc_to_data_o        = 1'b0;
    acc_to_x_o           = 1'b0;
    acc_to_y_o           = 1'b0;
    x_to_acc_o           = 1'b0;
    y_to_acc_o           = 1'b0;
    x_to_sp_o            = 1'b0;
    sp_to_x_o            = 1'b0;
    pc_low_to_addr_low_o = 1'b0;
    inc_pc_to_pc_o       = 1'b0;
    inc_pc_to_addr_o     = 1'b0;
    vector_hi_to_addr_o  = 1'b0;
    load_opcode          = 1'b0;
    finish               = 1'b0;
    bus_read             = 1'b0;
    bus_write            = 1'b0;
    next_stage           = stage;

    case (stage)
      STAGE_FETCH: begin
        if (data_valid_i) begin
          next_stage  = STAGE_1;
          load_opcode = 1'b1;
          // Sum of the previous ADC lands here
          hold_to_acc_o = (opcode == OP_ADC_IMM);
          case (data_i)
            OP_NOP, OP_TAX, OP_TAY, OP_TXA, OP_TYA, OP_TXS, OP_TSX: begin
            end
            default: begin
              // Point at the operand byte
              inc_pc_to_pc_o   = 1'b1;
              inc_pc_to_addr_o = 1'b1;
              bus_read         = 1'b1;
            end
          endcase
        end
      end

      STAGE_1: begin
        case (opcode)
          OP_TAX: begin
            acc_to_x_o = 1'b1;
            finish     = 1'b1;
          end
          OP_TAY: begin
            acc_to_y_o = 1'b1;
            finish     = 1'b1;
          end
          OP_TXA: begin
            x_to_acc_o = 1'b1;
            finish     = 1'b1;
          end
          OP_TYA: begin
            y_to_acc_o = 1'b1;
            finish     = 1'b1;
          end
          OP_TXS: begin
            x_to_sp_o = 1'b1;
            finish    = 1'b1;
          end
          OP_TSX: begin
            sp_to_x_o = 1'b1;
            finish    = 1'b1;
          end
          OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM: begin
            if (data_valid_i) begin
              data_to_acc_o = (opcode == OP_LDA_IMM);
              data_to_x_o   = (opcode == OP_LDX_IMM);
              data_to_y_o   = (opcode == OP_LDY_IMM);
              finish        = 1'b1;
            end
          end
          OP_ADC_IMM: begin
            if (data_valid_i) begin
              acc_to_alu_o  = 1'b1;
              alu_to_hold_o = 1'b1;
              finish        = 1'b1;
            end
          end
          OP_STA_ZP: begin
            if (data_valid_i) begin
              next_stage          = STAGE_2;
              data_to_addr_low_o  = 1'b1;
              zero_to_addr_high_o = 1'b1;
              acc_to_data_o       = 1'b1;
              bus_write           = 1'b1;
            end
          end
          OP_LDA_ZP, OP_LDX_ZP, OP_LDY_ZP: begin
            if (data_valid_i) begin
              next_stage          = STAGE_2;
              data_to_addr_low_o  = 1'b1;
              zero_to_addr_high_o = 1'b1;
              bus_read            = 1'b1;
            end
          end
          OP_LDA_ZPX: begin
            if (data_valid_i) begin
              next_stage    = STAGE_2;
              x_to_alu_o    = 1'b1;
              alu_to_hold_o = 1'b1;
            end
          end
          OP_LDA_ABS: begin
            if (data_valid_i) begin
              next_stage       = STAGE_2;
              data_to_hold_o   = 1'b1;
              inc_pc_to_addr_o = 1'b1;
              bus_read         = 1'b1;
            end
          end
          OP_JMP_ABS: begin
            if (data_valid_i) begin
              next_stage       = STAGE_2;
              data_to_pc_low_o = 1'b1;
              inc_pc_to_addr_o = 1'b1;
              bus_read         = 1'b1;
            end
          end
          // NOP and anything unknown step over one byte
          default: finish = 1'b1;
        endcase
      end

      STAGE_2: begin
        case (opcode)
          OP_LDA_ZP, OP_LDX_ZP, OP_LDY_ZP: begin
            if (data_valid_i) begin
              data_to_acc_o = (opcode == OP_LDA_ZP);
              data_to_x_o   = (opcode == OP_LDX_ZP);
              data_to_y_o   = (opcode == OP_LDY_ZP);
              finish        = 1'b1;
            end
          end
          OP_LDA_ZPX: begin
            next_stage          = STAGE_3;
            hold_to_addr_low_o  = 1'b1;
            zero_to_addr_high_o = 1'b1;
            bus_read            = 1'b1;
          end
          OP_LDA_ABS: begin
            if (data_valid_i) begin
              next_stage          = STAGE_3;
              hold_to_addr_low_o  = 1'b1;
              data_to_addr_high_o = 1'b1;
              inc_pc_to_pc_o      = 1'b1;
              bus_read            = 1'b1;
            end
          end
          OP_JMP_ABS: begin
            if (data_valid_i) begin
              next_stage           = STAGE_FETCH;
              data_to_pc_high_o    = 1'b1;
              pc_low_to_addr_low_o = 1'b1;
              data_to_addr_high_o  = 1'b1;
              bus_read             = 1'b1;
            end
          end
          // STA write is done
          default: finish = 1'b1;
        endcase
      end

      STAGE_3: begin
        if (data_valid_i) begin
          data_to_acc_o = 1'b1;
          finish        = 1'b1;
        end
      end

      STAGE_RESET_LO: begin
        if (data_valid_i) begin
          next_stage          = STAGE_RESET_HI;
          data_to_pc_low_o    = 1'b1;
          vector_hi_to_addr_o = 1'b1;
          bus_read            = 1'b1;
        end
      end

      STAGE_RESET_HI: begin
        if (data_valid_i) begin
          next_stage           = STAGE_FETCH;
          data_to_pc_high_o    = 1'b1;
          pc_low_to_addr_low_o = 1'b1;
          data_to_addr_high_o  = 1'b1;
          bus_read             = 1'b1;
        end
      end

      default: next_stage = STAGE_RESET_LO;
    endcase

    // Last step of an instruction, move on to the next opcode
    if (finish) begin
      next_stage       = STAGE_FETCH;
      inc_pc_to_pc_o   = 1'b1;
      inc_pc_to_addr_o = 1'b1;
      bus_read         = 1'b1;
    end
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      stage       <= STAGE_RESET_LO;
      opcode      <= OP_NOP;
      bus_read_o  <= 1'b1;
      bus_write_o <= 1'b0;
    end else if (step_i) begin
      stage <= next_stage;
      if (load_opcode) begin
        opcode <= data_i;
      end
      // Bus levels hold while a stage waits for data
      if (next_stage != stage) begin
        bus_read_o  <= bus_read;
        bus_write_o <= bus_write;
      end
    end
  end

endmodule

// ==== cpu_core/cpu_datapath.sv ====
`timescale 1ns/1ps

module cpu_datapath
  import cpu_pkg::*;
(
  input  logic  clock_i,
  input  logic  reset_i,
  input  logic  step_i,
  input  byte_t data_i,
  input  logic  data_to_acc_i,
  input  logic  data_to_x_i,
  input  logic  data_to_y_i,
  input  logic  data_to_addr_low_i,
  input  logic  data_to_addr_high_i,
  input  logic  zero_to_addr_high_i,
  input  logic  data_to_pc_low_i,
  input  logic  data_to_pc_high_i,
  input  logic  data_to_hold_i,
  input  logic  hold_to_addr_low_i,
  input  logic  hold_to_acc_i,
  input  logic  acc_to_alu_i,
  input  logic  x_to_alu_i,
  input  logic  alu_to_hold_i,
  input  logic  acc_to_data_i,
  input  logic  acc_to_x_i,
  input  logic  acc_to_y_i,
  input  logic  x_to_acc_i,
  input  logic  y_to_acc_i,
  input  logic  x_to_sp_i,
  input  logic  sp_to_x_i,
  input  logic  pc_low_to_addr_low_i,
  input  logic  inc_pc_to_pc_i,
  input  logic  inc_pc_to_addr_i,
  input  logic  vector_hi_to_addr_i,
  output addr_t address_o,
  output byte_t data_o
);

  // Programmer visible
  byte_t accumulator;
  byte_t index_x;
  byte_t index_y;
  byte_t stack_pointer;
  byte_t pc_high;
  byte_t pc_low;

  // Internal
  byte_t adder_hold;
  byte_t address_high;
  byte_t address_low;
  byte_t data_output;

  addr_t pc_plus_one;
  byte_t alu_a;
  byte_t alu_sum;

  assign pc_plus_one = {pc_high, pc_low} + 16'd1;

  always_comb begin
    alu_a = '0;
    if (acc_to_alu_i) begin
      alu_a = accumulator;
    end
    if (x_to_alu_i) begin
      alu_a = index_x;
    end
  end

  // Carry is dropped, sum wraps at 256
  assign alu_sum = alu_a + data_i;

  // Later strobes in each chain take priority
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      {address_high, address_low} <= VECTOR_LO_ADDR;
      accumulator   <= '0;
      index_x       <= '0;
      index_y       <= '0;
      stack_pointer <= '0;
    end else if (step_i) begin
      if (data_to_acc_i) accumulator <= data_i;
      if (hold_to_acc_i) accumulator <= adder_hold;
      if (x_to_acc_i) accumulator <= index_x;
      if (y_to_acc_i) accumulator <= index_y;

      if (data_to_x_i) index_x <= data_i;
      if (acc_to_x_i) index_x <= accumulator;
      if (sp_to_x_i) index_x <= stack_pointer;

      if (data_to_y_i) index_y <= data_i;
      if (acc_to_y_i) index_y <= accumulator;

      if (x_to_sp_i) stack_pointer <= index_x;

      if (zero_to_addr_high_i) address_high <= '0;
      if (data_to_addr_low_i) address_low <= data_i;
      if (data_to_addr_high_i) address_high <= data_i;
      if (pc_low_to_addr_low_i) address_low <= pc_low;
      if (inc_pc_to_addr_i) {address_high, address_low} <= pc_plus_one;
      if (vector_hi_to_addr_i) {address_high, address_low} <= VECTOR_HI_ADDR;
      if (hold_to_addr_low_i) address_low <= adder_hold;
    end
  end

  always_ff @(posedge clock_i) begin
    if (step_i) begin
      if (data_to_pc_low_i) pc_low <= data_i;
      if (data_to_pc_high_i) pc_high <= data_i;
      if (inc_pc_to_pc_i) {pc_high, pc_low} <= pc_plus_one;

      if (data_to_hold_i) adder_hold <= data_i;
      if (alu_to_hold_i) adder_hold <= alu_sum;

      if (acc_to_data_i) data_output <= accumulator;
    end
  end

  assign address_o = {address_high, address_low};
  assign data_o    = data_output;

endmodule

// ==== verilog/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top
  import cpu_pkg::*;
#(
  parameter int unsigned CLOCK_DIVIDER = 4
) (
  input  logic  clock_i,
  input  logic  reset_i,
  input  byte_t data_i,
  input  logic  data_valid_i,
  output byte_t data_o,
  output addr_t address_o,
  output logic  bus_read_o,
  output logic  bus_write_o
);

  logic step;

  // Register transfer strobes
  logic data_to_acc;
  logic data_to_x;
  logic data_to_y;
  logic data_to_addr_low;
  logic data_to_addr_high;
  logic zero_to_addr_high;
  logic data_to_pc_low;
  logic data_to_pc_high;
  logic data_to_hold;
  logic hold_to_addr_low;
  logic hold_to_acc;
  logic acc_to_alu;
  logic x_to_alu;
  logic alu_to_hold;
  logic acc_to_data;
  logic acc_to_x;
  logic acc_to_y;
  logic x_to_acc;
  logic y_to_acc;
  logic x_to_sp;
  logic sp_to_x;
  logic pc_low_to_addr_low;
  logic inc_pc_to_pc;
  logic inc_pc_to_addr;
  logic vector_hi_to_addr;

  clock_enable #(
    .CLOCK_DIVIDER(CLOCK_DIVIDER)
  ) clock_enable0 (
    .clock_i(clock_i),
    .reset_i(reset_i),
    .step_o (step)
  );

  cpu_control control0 (
    .clock_i             (clock_i),
    .reset_i             (reset_i),
    .step_i              (step),
    .data_i              (data_i),
    .data_valid_i        (data_valid_i),
    .bus_read_o          (bus_read_o),
    .bus_write_o         (bus_write_o),
    .data_to_acc_o       (data_to_acc),
    .data_to_x_o         (data_to_x),
    .data_to_y_o         (data_to_y),
    .data_to_addr_low_o  (data_to_addr_low),
    .data_to_addr_high_o (data_to_addr_high),
    .zero_to_addr_high_o (zero_to_addr_high),
    .data_to_pc_low_o    (data_to_pc_low),
    .data_to_pc_high_o   (data_to_pc_high),
    .data_to_hold_o      (data_to_hold),
    .hold_to_addr_low_o  (hold_to_addr_low),
    .hold_to_acc_o       (hold_to_acc),
    .acc_to_alu_o        (acc_to_alu),
    .x_to_alu_o          (x_to_alu),
    .alu_to_hold_o       (alu_to_hold),
    .acc_to_data_o       (acc_to_data),
    .acc_to_x_o          (acc_to_x),
    .acc_to_y_o          (acc_to_y),
    .x_to_acc_o          (x_to_acc),
    .y_to_acc_o          (y_to_acc),
    .x_to_sp_o           (x_to_sp),
    .sp_to_x_o           (sp_to_x),
    .pc_low_to_addr_low_o(pc_low_to_addr_low),
    .inc_pc_to_pc_o      (inc_pc_to_pc),
    .inc_pc_to_addr_o    (inc_pc_to_addr),
    .vector_hi_to_addr_o (vector_hi_to_addr)
  );

  cpu_datapath datapath0 (
    .clock_i             (clock_i),
    .reset_i             (reset_i),
    .step_i              (step),
    .data_i              (data_i),
    .data_to_acc_i       (data_to_acc),
    .data_to_x_i         (data_to_x),
    .data_to_y_i         (data_to_y),
    .data_to_addr_low_i  (data_to_addr_low),
    .data_to_addr_high_i (data_to_addr_high),
    .zero_to_addr_high_i (zero_to_addr_high),
    .data_to_pc_low_i    (data_to_pc_low),
    .data_to_pc_high_i   (data_to_pc_high),
    .data_to_hold_i      (data_to_hold),
    .hold_to_addr_low_i  (hold_to_addr_low),
    .hold_to_acc_i       (hold_to_acc),
    .acc_to_alu_i        (acc_to_alu),
    .x_to_alu_i          (x_to_alu),
    .alu_to_hold_i       (alu_to_hold),
    .acc_to_data_i       (acc_to_data),
    .acc_to_x_i          (acc_to_x),
    .acc_to_y_i          (acc_to_y),
    .x_to_acc_i          (x_to_acc),
    .y_to_acc_i          (y_to_acc),
    .x_to_sp_i           (x_to_sp),
    .sp_to_x_i           (sp_to_x),
    .pc_low_to_addr_low_i(pc_low_to_addr_low),
    .inc_pc_to_pc_i      (inc_pc_to_pc),
    .inc_pc_to_addr_i    (inc_pc_to_addr),
    .vector_hi_to_addr_i (vector_hi_to_addr),
    .address_o           (address_o),
    .data_o              (data_o)
  );

endmodule

// ==== testbench/cpu_tb_programs.svh ====
`ifndef CPU_TB_PROGRAMS_SVH
`define CPU_TB_PROGRAMS_SVH

// Memory image rows, {program[7:0], address[15:0], byte[7:0]}
// Each program carries its reset vector, code and zero-page data
localparam int NUM_PROGRAMS = 6;
localparam int IMAGE_COUNT  = 127;
localparam int WRITE_COUNT  = 15;

localparam logic [31:0] IMAGE_ROWS [IMAGE_COUNT] = '{
  // 0, reset vector to 1234, LDA #5A then STA
  32'h00_FFFC_34, 32'h00_FFFD_12,
  32'h00_1234_A9, 32'h00_1235_5A, 32'h00_1236_85, 32'h00_1237_10,
  32'h00_1238_4C, 32'h00_1239_38, 32'h00_123A_12,
  // 1, immediate and zero-page loads of A, X and Y
  32'h01_FFFC_00, 32'h01_FFFD_02,
  32'h01_0200_A9, 32'h01_0201_11, 32'h01_0202_85, 32'h01_0203_20,
  32'h01_0204_A2, 32'h01_0205_22, 32'h01_0206_8A, 32'h01_0207_85,
  32'h01_0208_21, 32'h01_0209_A0, 32'h01_020A_33, 32'h01_020B_98,
  32'h01_020C_85, 32'h01_020D_22, 32'h01_020E_A6, 32'h01_020F_40,
  32'h01_0210_8A, 32'h01_0211_85, 32'h01_0212_23, 32'h01_0213_A4,
  32'h01_0214_41, 32'h01_0215_98, 32'h01_0216_85, 32'h01_0217_24,
  32'h01_0218_A5, 32'h01_0219_42, 32'h01_021A_85, 32'h01_021B_25,
  32'h01_021C_4C, 32'h01_021D_1C, 32'h01_021E_02,
  32'h01_0040_44, 32'h01_0041_55, 32'h01_0042_66,
  // 2, ADC immediate, second sum wraps past FF
  32'h02_FFFC_00, 32'h02_FFFD_03,
  32'h02_0300_A9, 32'h02_0301_70, 32'h02_0302_69, 32'h02_0303_25,
  32'h02_0304_85, 32'h02_0305_30, 32'h02_0306_A9, 32'h02_0307_F0,
  32'h02_0308_69, 32'h02_0309_25, 32'h02_030A_85, 32'h02_030B_31,
  32'h02_030C_4C, 32'h02_030D_0C, 32'h02_030E_03,
  // 3, zero-page X wraps to 02, absolute load from 5634
  32'h03_FFFC_00, 32'h03_FFFD_40,
  32'h03_4000_A2, 32'h03_4001_05, 32'h03_4002_B5, 32'h03_4003_FD,
  32'h03_4004_85, 32'h03_4005_50, 32'h03_4006_AD, 32'h03_4007_34,
  32'h03_4008_56, 32'h03_4009_85, 32'h03_400A_51, 32'h03_400B_4C,
  32'h03_400C_0B, 32'h03_400D_40,
  32'h03_0002_C3, 32'h03_5634_7E,
  // 4, TXS and TSX, then TAX and TAY round trips
  32'h04_FFFC_00, 32'h04_FFFD_80,
  32'h04_8000_A2, 32'h04_8001_9C, 32'h04_8002_9A, 32'h04_8003_A2,
  32'h04_8004_00, 32'h04_8005_BA, 32'h04_8006_8A, 32'h04_8007_85,
  32'h04_8008_60, 32'h04_8009_A9, 32'h04_800A_3D, 32'h04_800B_AA,
  32'h04_800C_A9, 32'h04_800D_00, 32'h04_800E_8A, 32'h04_800F_85,
  32'h04_8010_61, 32'h04_8011_A9, 32'h04_8012_E7, 32'h04_8013_A8,
  32'h04_8014_A9, 32'h04_8015_00, 32'h04_8016_98, 32'h04_8017_85,
  32'h04_8018_62, 32'h04_8019_4C, 32'h04_801A_19, 32'h04_801B_80,
  // 5, JMP over a store to a NOP and the target store
  32'h05_FFFC_00, 32'h05_FFFD_C0,
  32'h05_C000_4C, 32'h05_C001_10, 32'h05_C002_C0,
  32'h05_C003_A9, 32'h05_C004_11, 32'h05_C005_85, 32'h05_C006_70,
  32'h05_C010_EA, 32'h05_C011_A9, 32'h05_C012_A5, 32'h05_C013_85,
  32'h05_C014_71, 32'h05_C015_4C, 32'h05_C016_15, 32'h05_C017_C0
};

// Expected bus writes in order, {program[7:0], address[15:0], data[7:0]}
localparam logic [31:0] WRITE_ROWS [WRITE_COUNT] = '{
  32'h00_0010_5A,
  32'h01_0020_11, 32'h01_0021_22, 32'h01_0022_33,
  32'h01_0023_44, 32'h01_0024_55, 32'h01_0025_66,
  32'h02_0030_95, 32'h02_0031_15,
  32'h03_0050_C3, 32'h03_0051_7E,
  32'h04_0060_9C, 32'h04_0061_3D, 32'h04_0062_E7,
  32'h05_0071_A5
};

`endif

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb
  import cpu_pkg::*;
();

  localparam int CLOCK_DIVIDER  = 4;
  localparam int TIMEOUT_CLOCKS = 2000;

  `include "cpu_tb_programs.svh"

  logic  clock_i;
  logic  reset_i;
  byte_t data_i;
  logic  data_valid_i;
  byte_t data_o;
  addr_t address_o;
  logic  bus_read_o;
  logic  bus_write_o;

  byte_t mem [0:65535];
  addr_t write_addr_q [$];
  byte_t write_data_q [$];
  logic  write_seen;
  int    write_clocks;

  cpu_top #(
    .CLOCK_DIVIDER(CLOCK_DIVIDER)
  ) dut0 (
    .clock_i     (clock_i),
    .reset_i     (reset_i),
    .data_i      (data_i),
    .data_valid_i(data_valid_i),
    .data_o      (data_o),
    .address_o   (address_o),
    .bus_read_o  (bus_read_o),
    .bus_write_o (bus_write_o)
  );

  initial begin
    clock_i = 1'b0;
    forever #10 clock_i = ~clock_i;
  end

  // Memory answers the current address shortly after each edge
  always @(posedge clock_i) begin
    #1;
    data_i <= mem[address_o];
  end

  // One write per rising edge of the write level
  always @(negedge clock_i) begin
    if (bus_write_o && !write_seen) begin
      write_addr_q.push_back(address_o);
      write_data_q.push_back(data_o);
      mem[address_o] = data_o;
      write_clocks = 0;
    end
    // A write lasts exactly one step
    if (bus_write_o) begin
      write_clocks++;
    end else if (write_seen) begin
      check_equal(32'(write_clocks), 32'(CLOCK_DIVIDER), "write level length in clocks");
    end
    write_seen = bus_write_o;
  end

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("SOME TESTS FAILED");
      $fatal(1, "Value mismatch");
    end
  endtask

  // Background pattern mixes both address bytes
  task automatic load_image(input int prog);
    for (int a = 0; a < 65536; a++) begin
      mem[a[15:0]] = a[15:8] ^ a[7:0] ^ 8'hA5;
    end
    foreach (IMAGE_ROWS[i]) begin
      if (IMAGE_ROWS[i][31:24] == 8'(prog)) begin
        mem[IMAGE_ROWS[i][23:8]] = IMAGE_ROWS[i][7:0];
      end
    end
  endtask

  initial begin
    logic [31:0] expected_q [$];
    int cycles;

    reset_i      = 1'b1;
    data_i       = '0;
    data_valid_i = 1'b1;
    write_seen   = 1'b0;

    for (int prog = 0; prog < NUM_PROGRAMS; prog++) begin
      @(posedge clock_i);
      #1;
      reset_i = 1'b1;
      load_image(prog);
      expected_q.delete();
      foreach (WRITE_ROWS[i]) begin
        if (WRITE_ROWS[i][31:24] == 8'(prog)) begin
          expected_q.push_back(WRITE_ROWS[i]);
        end
      end
      repeat (3) @(posedge clock_i);
      write_addr_q.delete();
      write_data_q.delete();
      #1;
      reset_i = 1'b0;
      check_equal(32'(address_o), 32'(VECTOR_LO_ADDR), "address after reset");
      check_equal(32'(bus_read_o), 32'd1, "read level after reset");
      check_equal(32'(bus_write_o), 32'd0, "write level after reset");

      // Also wait for the last write level to drop
      cycles = 0;
      while (write_addr_q.size() < expected_q.size() || write_seen) begin
        @(posedge clock_i);
        cycles++;
        if (cycles > TIMEOUT_CLOCKS) begin
          $display("Program %0d timed out waiting for %0d bus writes, saw %0d",
                   prog, expected_q.size(), write_addr_q.size());
          $display("SOME TESTS FAILED");
          $fatal(1, "Timeout");
        end
      end

      foreach (expected_q[i]) begin
        check_equal(32'(write_addr_q[i]), 32'(expected_q[i][23:8]),
                    $sformatf("program %0d write %0d address", prog, i));
        check_equal(32'(write_data_q[i]), 32'(expected_q[i][7:0]),
                    $sformatf("program %0d write %0d data", prog, i));
      end
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+testbench
common/cpu_pkg.sv
verilog/clock_enable.sv
cpu_core/cpu_control.sv
cpu_core/cpu_datapath.sv
verilog/cpu_top.sv
testbench/cpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" &&
verilator --binary --timing -f build.f --top-module cpu_tb -o cpu_sim &&
./obj_dir/cpu_sim | grep -q "ALL TESTS PASSED" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
